//--- tb.f
+incdir+include
logic/mul_pkg.sv
logic/mul_step_if.sv
logic/mul_ctrl.sv
logic/mul_operand_prep.sv
logic/mul_booth_datapath.sv
logic/mul_result_sel.sv
logic/mul_top.sv
dv/mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the multiply unit testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mul_tb -f tb.f \
    --Mdir obj_dir -o mul_tb_sim > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/mul_tb_sim > sim.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed, see sim.log"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

//--- dv/mul_tb.sv
// Testbench for mul_top with clock, reset, stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_tb;
    import mul_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RAND_SEED      = 32'hdc31_8274;
    localparam int LATENCY        = 18;
    localparam int MAX_STALL      = 20;
    localparam int N_DIRECTED     = 4 * 5 * 5;
    localparam int N_RANDOM       = 200;
    localparam int N_LATENCY      = 10;
    localparam int N_BACKPRESSURE = 30;
    localparam int TOTAL_OPS      = N_DIRECTED + N_RANDOM + N_LATENCY + N_BACKPRESSURE;
    // Idle wait, accept and pulse check on top of latency and stall
    localparam int OP_CYCLES      = LATENCY + MAX_STALL + 3;
    localparam int WATCHDOG_NS    = (TOTAL_OPS * OP_CYCLES + 200) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    xlen_t   a_i;
    xlen_t   b_i;
    mul_op_t op_sel_i;
    logic    in_valid_i;
    logic    out_ready_i;
    logic    in_ready_o;
    logic    out_valid_o;
    prod_t   result_o;

    int errors;
    int op_count;
    int tests_done;

    mul_top mul_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_i         (a_i),
        .b_i         (b_i),
        .op_sel_i    (op_sel_i),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .result_o    (result_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Reference model and reporting
    // --------------------------------------------------
    // Exact product of the extended operands, then pick the word per op
    function automatic prod_t model_result(input xlen_t a, input xlen_t b, input mul_op_t op);
        logic               sa;
        logic               sb;
        logic signed [65:0] ext_a;
        logic signed [65:0] ext_b;
        logic signed [65:0] full;
        xlen_t              hi;
        sa    = (op != `MUL_OP_MULHU) & a[31];
        sb    = ((op == `MUL_OP_MUL) || (op == `MUL_OP_MULH)) & b[31];
        ext_a = {{34{sa}}, a};
        ext_b = {{34{sb}}, b};
        full  = ext_a * ext_b;
        hi    = full[63:32];
        if (op == `MUL_OP_MUL) begin
            return full[63:0];
        end else if (op == `MUL_OP_MULHU) begin
            return {32'h0, hi};
        end
        return {{32{hi[31]}}, hi};
    endfunction

    function automatic xlen_t corner_value(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_bit(input string name, input logic exp, input logic act);
        $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before, input int ops_before);
        $display("test %-14s %0d ops, %0d errors", name, op_count - ops_before,
                 errors - errs_before);
        tests_done++;
    endtask

    // --------------------------------------------------
    // One operation through both handshakes
    // --------------------------------------------------
    // Called #1 after a rising edge; returns at the same phase
    task automatic run_op(input xlen_t a, input xlen_t b, input mul_op_t op,
                          input int stall, input bit scramble);
        prod_t       exp;
        prod_t       prev;
        int          k;
        int          wait_cycles;
        bit          seen;
        logic [31:0] r;
        exp         = model_result(a, b, op);
        wait_cycles = 0;
        while ((in_ready_o !== 1'b1) && (wait_cycles < 50)) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (in_ready_o !== 1'b1) begin
            $display("ERROR t=%0t in_ready_o did not return high before a new operation", $time);
            errors++;
        end
        prev        = result_o;
        a_i         = a;
        b_i         = b;
        op_sel_i    = op;
        in_valid_i  = 1'b1;
        out_ready_i = (stall == 0);
        seen        = 1'b0;
        // Accept edge counts as cycle zero
        k           = -1;
        while (!seen && (k < LATENCY + stall + 5)) begin
            @(posedge clk);
            #1;
            k++;
            if (out_valid_o === 1'b1) begin
                seen = 1'b1;
                if (k != LATENCY + stall) begin
                    $display("ERROR t=%0t out_valid_o rose %0d cycles after acceptance, not %0d",
                             $time, k, LATENCY + stall);
                    errors++;
                end
                if (result_o !== exp) begin
                    report_mismatch("result_o", exp, result_o);
                end
                if (in_ready_o !== 1'b1) begin
                    report_bit("in_ready_o", 1'b1, in_ready_o);
                end
                in_valid_i = 1'b0;
            end else begin
                // Busy or held in DONE
                if (in_ready_o !== 1'b0) begin
                    report_bit("in_ready_o", 1'b0, in_ready_o);
                end
                if (result_o !== prev) begin
                    report_mismatch("result_o", prev, result_o);
                end
                if (scramble) begin
                    r          = $urandom;
                    a_i        = r;
                    r          = $urandom;
                    b_i        = r;
                    r          = $urandom;
                    op_sel_i   = r[1:0];
                    in_valid_i = 1'b1;
                end else begin
                    in_valid_i = 1'b0;
                end
                // DONE is reached at k = 17, release after the stall
                if (k == LATENCY - 1 + stall) begin
                    out_ready_i = 1'b1;
                end
            end
        end
        if (!seen) begin
            $display("ERROR t=%0t no out_valid_o pulse within %0d cycles of acceptance",
                     $time, k);
            errors++;
        end
        // Valid is a single-cycle pulse
        @(posedge clk);
        #1;
        if (out_valid_o !== 1'b0) begin
            report_bit("out_valid_o", 1'b0, out_valid_o);
        end
        op_count++;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int          e0;
        int          o0;
        int          stall;
        logic [31:0] r;
        xlen_t       ra;
        xlen_t       rb;
        clk         = 1'b0;
        rst_n       = 1'b0;
        a_i         = '0;
        b_i         = '0;
        op_sel_i    = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        errors      = 0;
        op_count    = 0;
        tests_done  = 0;
        void'($urandom(RAND_SEED));

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values
        e0 = errors;
        o0 = op_count;
        if (in_ready_o !== 1'b1) begin
            report_bit("in_ready_o", 1'b1, in_ready_o);
        end
        if (out_valid_o !== 1'b0) begin
            report_bit("out_valid_o", 1'b0, out_valid_o);
        end
        if (result_o !== 64'h0) begin
            report_mismatch("result_o", 64'h0, result_o);
        end
        finish_test("reset_state", e0, o0);

        // Every op on every pairing of corner operands
        e0 = errors;
        o0 = op_count;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_op(corner_value(i), corner_value(j), 2'(op), 0, 1'b0);
                end
            end
        end
        finish_test("directed", e0, o0);

        e0 = errors;
        o0 = op_count;
        for (int n = 0; n < N_RANDOM; n++) begin
            ra = $urandom;
            rb = $urandom;
            r  = $urandom;
            run_op(ra, rb, r[1:0], 0, 1'b0);
        end
        finish_test("random", e0, o0);

        // Latency and in_ready_o are checked cycle by cycle in run_op
        e0 = errors;
        o0 = op_count;
        for (int n = 0; n < N_LATENCY; n++) begin
            ra = $urandom;
            rb = $urandom;
            r  = $urandom;
            run_op(ra, rb, r[1:0], 0, 1'b0);
        end
        finish_test("fixed_latency", e0, o0);

        // Random stall with operands churning while busy
        e0 = errors;
        o0 = op_count;
        for (int n = 0; n < N_BACKPRESSURE; n++) begin
            ra    = $urandom;
            rb    = $urandom;
            r     = $urandom;
            stall = $urandom_range(MAX_STALL, 0);
            run_op(ra, rb, r[1:0], stall, 1'b1);
        end
        finish_test("backpressure", e0, o0);

        $display("tests %0d, operations %0d, errors %0d", tests_done, op_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Run length bound from the op count and worst-case stall
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR t=%0t watchdog expired before the tests completed", $time);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/mul_top.sv
// Multiply unit top level wiring sequencer and Booth datapath to plain ports
`timescale 1ns/1ps
`default_nettype none

module mul_top (
    input  logic             clk,
    input  logic             rst_n,
    input  mul_pkg::xlen_t   a_i,
    input  mul_pkg::xlen_t   b_i,
    input  mul_pkg::mul_op_t op_sel_i,
    input  logic             in_valid_i,
    input  logic             out_ready_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output mul_pkg::prod_t   result_o
);
    import mul_pkg::*;

    // Extended operands from prep
    opnd_t mcand;
    opnd_t mplier;
    // Finished product from the Booth engine
    prod_t product;

    mul_step_if step_if ();

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    mul_ctrl mul_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .op_sel_i    (op_sel_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .step        (step_if.ctrl)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    mul_operand_prep mul_operand_prep_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_i      (a_i),
        .b_i      (b_i),
        .step     (step_if.dp),
        .mcand_o  (mcand),
        .mplier_o (mplier)
    );

    mul_booth_datapath mul_booth_datapath_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step_if.dp),
        .mcand_i   (mcand),
        .mplier_i  (mplier),
        .product_o (product)
    );

    mul_result_sel mul_result_sel_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step_if.sel),
        .product_i (product),
        .result_o  (result_o)
    );

endmodule

`default_nettype wire

//--- logic/mul_result_sel.sv
// Result selection between full product and extended high word, with output register
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_result_sel (
    input  logic           clk,
    input  logic           rst_n,
    mul_step_if.sel        step,
    input  mul_pkg::prod_t product_i,
    output mul_pkg::prod_t result_o
);
    import mul_pkg::*;

    xlen_t hi_word;
    logic  hi_sgn;
    prod_t result_d;

    assign hi_word = product_i[2*`MUL_XLEN-1:`MUL_XLEN];
    // MULHU zero-extends and the others sign-extend
    assign hi_sgn  = (step.op != `MUL_OP_MULHU) & hi_word[`MUL_XLEN-1];

    always_comb begin
        if (step.op == `MUL_OP_MUL) begin
            result_d = product_i;
        end else begin
            result_d = {{`MUL_XLEN{hi_sgn}}, hi_word};
        end
    end

    // Loads on the output handshake and holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_o <= '0;
        end else if (step.capture) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_booth_datapath.sv
// Radix-4 Booth partial-product accumulator and multiplier shifter
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_booth_datapath (
    input  logic           clk,
    input  logic           rst_n,
    mul_step_if.dp         step,
    input  mul_pkg::opnd_t mcand_i,
    input  mul_pkg::opnd_t mplier_i,
    output mul_pkg::prod_t product_o
);
    import mul_pkg::*;

    acc_t                 acc_q;
    acc_t                 acc_nxt;
    logic                 hist_q;
    logic                 fresh_q;
    opnd_t                hi_cur;
    opnd_t                lo_cur;
    logic [2:0]           booth_bits;
    logic [`MUL_XLEN+2:0] mult;
    logic [`MUL_XLEN+2:0] sum;

    // --------------------------------------------------
    // Booth step
    // --------------------------------------------------
    // First step takes the multiplier straight from prep
    assign lo_cur     = fresh_q ? mplier_i : acc_q[`MUL_XLEN+1:0];
    assign hi_cur     = acc_q[2*`MUL_XLEN+3:`MUL_XLEN+2];
    assign booth_bits = {lo_cur[1:0], hist_q};

    // Recode to 0, +-1 or +-2 times the multiplicand
    always_comb begin
        case (booth_bits)
            3'b001, 3'b010: mult = {mcand_i[`MUL_XLEN+1], mcand_i};
            3'b011:         mult = {mcand_i, 1'b0};
            3'b100:         mult = -{mcand_i, 1'b0};
            3'b101, 3'b110: mult = -{mcand_i[`MUL_XLEN+1], mcand_i};
            default:        mult = '0;
        endcase
    end

    // One guard bit absorbs the +-2 multiple
    assign sum = {hi_cur[`MUL_XLEN+1], hi_cur} + mult;

    // Arithmetic shift right by two across the whole accumulator
    assign acc_nxt = {sum[`MUL_XLEN+2], sum, lo_cur[`MUL_XLEN+1:2]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_q  <= 1'b0;
            fresh_q <= 1'b0;
        end else if (step.load) begin
            hist_q  <= 1'b0;
            fresh_q <= 1'b1;
        end else if (step.advance) begin
            // Bit shifted out becomes the next history bit
            hist_q  <= lo_cur[1];
            fresh_q <= 1'b0;
        end
    end

    // Upper half cleared on load and lower half fills on the first step
    always_ff @(posedge clk) begin
        if (step.load) begin
            acc_q[2*`MUL_XLEN+3:`MUL_XLEN+2] <= '0;
        end else if (step.advance) begin
            acc_q <= acc_nxt;
        end
    end

    // Low word of the 68-bit signed product
    assign product_o = acc_q[2*`MUL_XLEN-1:0];

endmodule

`default_nettype wire

//--- logic/mul_operand_prep.sv
// Operand registers with per-operation sign or zero extension
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_operand_prep (
    input  logic           clk,
    input  logic           rst_n,
    input  mul_pkg::xlen_t a_i,
    input  mul_pkg::xlen_t b_i,
    mul_step_if.dp         step,
    output mul_pkg::opnd_t mcand_o,
    output mul_pkg::opnd_t mplier_o
);
    import mul_pkg::*;

    xlen_t a_q;
    xlen_t b_q;
    logic  mcand_sgn;
    logic  mplier_sgn;

    // Operands captured on the accept edge only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (step.load) begin
            a_q <= a_i;
            b_q <= b_i;
        end
    end

    // Multiplicand is signed unless MULHU
    assign mcand_sgn  = (step.op != `MUL_OP_MULHU);
    // Multiplier is signed for MUL and MULH
    assign mplier_sgn = (step.op == `MUL_OP_MUL) || (step.op == `MUL_OP_MULH);

    // Two extra bits let one signed Booth engine cover all four ops
    assign mcand_o  = {{2{mcand_sgn & a_q[`MUL_XLEN-1]}}, a_q};
    assign mplier_o = {{2{mplier_sgn & b_q[`MUL_XLEN-1]}}, b_q};

endmodule

`default_nettype wire

//--- logic/mul_ctrl.sv
// Valid/ready handshake and Booth sequencing FSM with step counter
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid_i,
    input  logic             out_ready_i,
    input  mul_pkg::mul_op_t op_sel_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    mul_step_if.ctrl         step
);
    import mul_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    step_cnt_t   cnt_q;
    mul_op_t     op_q;
    logic        out_valid_q;
    logic        load;
    logic        capture;
    logic        last_step;

    // --------------------------------------------------
    // Handshake decode
    // --------------------------------------------------
    // Only one operation in flight
    assign in_ready_o = (state_q == IDLE);
    assign load       = in_ready_o & in_valid_i;
    // Result leaves only when the consumer is ready
    assign capture    = (state_q == DONE) & out_ready_i;
    // Counter sits on the last iteration
    assign last_step  = (cnt_q == step_cnt_t'(`MUL_STEPS - 1));

    assign step.load    = load;
    assign step.advance = (state_q == RUN);
    assign step.capture = capture;
    assign step.op      = op_q;
    assign out_valid_o  = out_valid_q;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // Leave after the final Booth step
                if (last_step) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                // Back-pressure holds here
                if (capture) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            op_q        <= `MUL_OP_MUL;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // One-cycle valid pulse on the capture edge
            out_valid_q <= capture;
            if (load) begin
                cnt_q <= '0;
                op_q  <= op_sel_i;
            end else if (state_q == RUN) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_step_if.sv
// Step control interface from the sequencer to the datapath blocks
`timescale 1ns/1ps
`default_nettype none

interface mul_step_if;
    import mul_pkg::*;

    // Single pulse on the accept edge
    logic    load;
    // High for every Booth iteration
    logic    advance;
    // Single pulse on the output handshake
    logic    capture;
    // Operation code held from acceptance
    mul_op_t op;

    // Sequencer drives everything
    modport ctrl (
        output load,
        output advance,
        output capture,
        output op
    );

    // Operand prep and Booth engine
    modport dp (
        input load,
        input advance,
        input op
    );

    // Output register
    modport sel (
        input capture,
        input op
    );

endinterface

`default_nettype wire

//--- logic/mul_pkg.sv
// Vector typedefs and control state enum for the multiply unit
`default_nettype none

`include "mul_defs.svh"

package mul_pkg;

    // Operand word as seen on the ports
    typedef logic [`MUL_XLEN-1:0] xlen_t;

    // Full result word
    typedef logic [2*`MUL_XLEN-1:0] prod_t;

    // Operand widened by two bits for the signed Booth engine
    typedef logic [`MUL_XLEN+1:0] opnd_t;

    // Partial product on top and multiplier below
    typedef logic [2*`MUL_XLEN+3:0] acc_t;

    // Booth iteration counter
    typedef logic [$clog2(`MUL_STEPS)-1:0] step_cnt_t;

    // Operation select
    typedef logic [1:0] mul_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- include/mul_defs.svh
// Operand width, Booth step count and operation code macros
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand width in bits
`define MUL_XLEN 32

// Radix-4 iterations over the 34-bit extended multiplier
`define MUL_STEPS 17

// --------------------------------------------------
// Operation codes
// --------------------------------------------------
// Same order as the low bits of the M extension funct3
`define MUL_OP_MUL    2'd0
`define MUL_OP_MULH   2'd1
`define MUL_OP_MULHSU 2'd2
`define MUL_OP_MULHU  2'd3

`endif
